// File: project.f
hw/i2cPkg.sv
hw/i2cRequestRegs.sv
hw/i2cSequencer.sv
hw/i2cBitEngine.sv
hw/i2cReadAssembler.sv
hw/i2cMaster.sv
dv/i2cSensorModel.sv
dv/i2cMasterTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = i2cMasterTb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS     = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS)$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: dv/i2cMasterTb.sv
`timescale 1ns/1ps

module i2cMasterTb;

    // Room for about 20 transactions of up to 300 cycles each
    localparam int TimeoutCycles = 8000;
    localparam logic [6:0] SensorAddr = 7'h19;
    localparam logic [6:0] OtherAddr  = 7'h2C;

    logic              FSM_Clk;
    logic              reset;
    logic              startRequest;
    i2cPkg::addrT      slaveAddr;
    i2cPkg::addrT      subAddr;
    logic              readNotWrite;
    i2cPkg::byteT      writeData;
    i2cPkg::byteCountT byteCount;
    logic              sdaIn;
    logic              scl;
    logic              sdaOut;
    logic              sdaOe;
    logic              busy;
    logic              readDone;
    i2cPkg::readWordT  readData;
    logic              ackBit;
    logic              sensorPull;

    logic [31:0]       lfsrState;
    i2cPkg::byteT      expBank [128];
    int                cycleCount = 0;
    int                testErrors;
    int                testsRun;
    int                testsFailed;
    string             testName;

    // Wired AND of the two open-drain drivers
    assign sdaIn = (sdaOe ? sdaOut : 1'b1) && !sensorPull;

    i2cMaster uut (
        .FSM_Clk(FSM_Clk), .reset(reset), .startRequest(startRequest),
        .slaveAddr(slaveAddr), .subAddr(subAddr), .readNotWrite(readNotWrite),
        .writeData(writeData), .byteCount(byteCount), .sdaIn(sdaIn), .scl(scl),
        .sdaOut(sdaOut), .sdaOe(sdaOe), .busy(busy), .readDone(readDone),
        .readData(readData), .ackBit(ackBit)
    );

    i2cSensorModel sensor (
        .FSM_Clk(FSM_Clk), .reset(reset), .scl(scl), .sda(sdaIn), .sdaPull(sensorPull)
    );

    initial begin
        FSM_Clk = 1'b0;
        forever #10 FSM_Clk = ~FSM_Clk;
    end

    always @(posedge FSM_Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Random source and reference rules
    //////////////////////////////////////////////////////////////////////

    // Galois LFSR over x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic int clampCount(input i2cPkg::byteCountT count);
        if (count == 3'd0) begin
            return 1;
        end
        if (count > 3'd4) begin
            return 4;
        end
        return int'(count);
    endfunction

    // First byte read lands in the highest used byte lane
    function automatic logic [31:0] expectedRead(input logic [6:0] sub, input int count);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < count; k++) begin
            word[8 * (count - 1 - k) +: 8] = expBank[sub + 7'(k)];
        end
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Mismatch in %s (%s): expected %h, actual %h",
                     testName, what, expected, actual);
            testErrors++;
        end
    endtask

    task automatic requireTrue(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("Error in %s: %s", testName, what);
            testErrors++;
        end
    endtask

    task automatic beginTest(input string name);
        testName   = name;
        testErrors = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("%s: %s", testName, (testErrors == 0) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host side driving
    //////////////////////////////////////////////////////////////////////

    task automatic issueRequest(input logic [6:0] addr, input logic [6:0] sub, input logic rd,
                                input logic [7:0] data, input logic [2:0] count);
        @(negedge FSM_Clk);
        slaveAddr    = addr;
        subAddr      = sub;
        readNotWrite = rd;
        writeData    = data;
        byteCount    = count;
        startRequest = 1'b1;
        @(negedge FSM_Clk);
        startRequest = 1'b0;
    endtask

    task automatic waitIdle(output int donePulses);
        donePulses = 0;
        requireTrue("busy did not rise after the request", busy);
        while (busy === 1'b1) begin
            if (readDone === 1'b1) begin
                donePulses++;
            end
            @(negedge FSM_Clk);
        end
    endtask

    task automatic runTransaction(input logic [6:0] addr, input logic [6:0] sub, input logic rd,
                                  input logic [7:0] data, input logic [2:0] count,
                                  output int donePulses);
        issueRequest(addr, sub, rd, data, count);
        waitIdle(donePulses);
    endtask

    task automatic checkRead(input logic [6:0] sub, input logic [2:0] count);
        int donePulses;
        int bytes;
        int startsBefore;
        int acksBefore;
        int nacksBefore;
        bytes        = clampCount(count);
        startsBefore = sensor.startCount;
        acksBefore   = sensor.ackCount;
        nacksBefore  = sensor.nackCount;
        runTransaction(SensorAddr, sub, 1'b1, 8'h00, count, donePulses);
        compareValue("readData", expectedRead(sub, bytes), readData);
        compareValue("master ACKs", 32'(bytes - 1), 32'(sensor.ackCount - acksBefore));
        compareValue("master NACKs", 32'd1, 32'(sensor.nackCount - nacksBefore));
        compareValue("readDone pulses", 32'd1, 32'(donePulses));
        compareValue("START count", 32'd2, 32'(sensor.startCount - startsBefore));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic [6:0] sub;
        logic [7:0] data;
        int         donePulses;
        int         startsBefore;
        lfsrState    = 32'hfee3_a736;
        testsRun     = 0;
        testsFailed  = 0;
        testErrors   = 0;
        testName     = "";
        reset        = 1'b1;
        startRequest = 1'b0;
        slaveAddr    = '0;
        subAddr      = '0;
        readNotWrite = 1'b0;
        writeData    = '0;
        byteCount    = '0;
        for (int i = 0; i < 128; i++) begin
            expBank[i] = 8'(i) ^ 8'h5A;
        end
        repeat (3) @(posedge FSM_Clk);
        @(negedge FSM_Clk);
        reset = 1'b0;

        beginTest("resetState");
        compareValue("busy", 32'd0, 32'(busy));
        compareValue("scl", 32'd1, 32'(scl));
        compareValue("sdaOe", 32'd0, 32'(sdaOe));
        compareValue("readDone", 32'd0, 32'(readDone));
        compareValue("readData", 32'd0, readData);
        compareValue("ackBit", 32'd1, 32'(ackBit));
        finishTest();

        beginTest("writeReadback");
        sub          = 7'(randomBits(7));
        data         = 8'(randomBits(8));
        startsBefore = sensor.startCount;
        runTransaction(SensorAddr, sub, 1'b0, data, 3'd1, donePulses);
        expBank[sub] = data;
        compareValue("write START count", 32'd1, 32'(sensor.startCount - startsBefore));
        compareValue("write readDone pulses", 32'd0, 32'(donePulses));
        compareValue("write ackBit", 32'd0, 32'(ackBit));
        startsBefore = sensor.startCount;
        runTransaction(SensorAddr, sub, 1'b1, 8'h00, 3'd1, donePulses);
        compareValue("readData", {24'h0, data}, readData);
        compareValue("read ackBit", 32'd0, 32'(ackBit));
        compareValue("read START count", 32'd2, 32'(sensor.startCount - startsBefore));
        compareValue("read readDone pulses", 32'd1, 32'(donePulses));
        finishTest();

        beginTest("multiRead");
        for (int n = 1; n <= 4; n++) begin
            checkRead(7'(randomBits(7)), 3'(n));
        end
        repeat (2) begin
            checkRead(7'(randomBits(7)), 3'(randomBits(2)) + 3'd1);
        end
        finishTest();

        beginTest("countClamp");
        checkRead(7'(randomBits(7)), 3'd0);
        checkRead(7'(randomBits(7)), 3'd6);
        finishTest();

        beginTest("wrongAddress");
        runTransaction(OtherAddr, 7'(randomBits(7)), 1'b1, 8'h00, 3'd2, donePulses);
        compareValue("ackBit", 32'd1, 32'(ackBit));
        compareValue("readData", 32'h0000_FFFF, readData);
        compareValue("readDone pulses", 32'd1, 32'(donePulses));
        finishTest();

        beginTest("busyIgnore");
        sub          = 7'(randomBits(7));
        data         = 8'(randomBits(8));
        startsBefore = sensor.startCount;
        issueRequest(SensorAddr, sub, 1'b0, data, 3'd1);
        repeat (5) @(negedge FSM_Clk);
        issueRequest(SensorAddr, sub + 7'd1, 1'b0, ~data, 3'd1);
        waitIdle(donePulses);
        expBank[sub] = data;
        repeat (4) @(negedge FSM_Clk);
        compareValue("busy after ignored request", 32'd0, 32'(busy));
        compareValue("START count", 32'd1, 32'(sensor.startCount - startsBefore));
        for (int i = 0; i < 128; i++) begin
            compareValue("bank entry", 32'(expBank[i]), 32'(sensor.bank[i]));
        end
        finishTest();

        beginTest("busChecker");
        compareValue("frame errors", 32'd0, 32'(sensor.frameErrors));
        finishTest();

        $display("Tests run: %0d, failing: %0d", testsRun, testsFailed);
        if (testsFailed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: dv/i2cSensorModel.sv
`timescale 1ns/1ps

module i2cSensorModel (
    input  logic FSM_Clk,
    input  logic reset,
    input  logic scl,
    input  logic sda,
    output logic sdaPull
);

    localparam logic [6:0] DeviceAddr = 7'h19;

    typedef enum logic [2:0] {
        modeIdle,
        modeAddr,
        modeReg,
        modeWrite,
        modeRead,
        modeIgnore
    } modeT;

    logic [7:0] bank [128];
    modeT       mode;
    logic       prevScl;
    logic       prevSda;
    // Set by an SCL rise, so the START's own SCL fall is not taken as a bit
    logic       inBit;
    logic [3:0] bitCnt;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [6:0] pointer;
    logic [6:0] nextPtr;
    logic       autoInc;
    logic       readDir;
    logic       masterAcked;
    int         startCount;
    int         ackCount;
    int         nackCount;
    int         frameErrors;

    assign nextPtr = autoInc ? pointer + 7'd1 : pointer;

    //////////////////////////////////////////////////////////////////////
    // Bus sampled mid-cycle, away from the master's clock edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge FSM_Clk) begin
        if (reset) begin
            for (int i = 0; i < 128; i++) begin
                bank[i] <= 8'(i) ^ 8'h5A;
            end
            mode        <= modeIdle;
            prevScl     <= 1'b1;
            prevSda     <= 1'b1;
            inBit       <= 1'b0;
            bitCnt      <= 4'd0;
            shiftIn     <= 8'h00;
            txByte      <= 8'h00;
            pointer     <= 7'd0;
            autoInc     <= 1'b0;
            readDir     <= 1'b0;
            masterAcked <= 1'b0;
            sdaPull     <= 1'b0;
            startCount  <= 0;
            ackCount    <= 0;
            nackCount   <= 0;
            frameErrors <= 0;
        end else begin
            prevScl <= scl;
            prevSda <= sda;
            if (prevScl && scl && prevSda && !sda) begin
                // START or repeated START, never in the middle of a frame
                if (mode != modeIdle && mode != modeIgnore && bitCnt != 4'd0) begin
                    frameErrors <= frameErrors + 1;
                end
                startCount <= startCount + 1;
                mode       <= modeAddr;
                bitCnt     <= 4'd0;
                inBit      <= 1'b0;
                sdaPull    <= 1'b0;
            end else if (prevScl && scl && !prevSda && sda) begin
                if (mode != modeIdle && mode != modeIgnore && bitCnt != 4'd0) begin
                    frameErrors <= frameErrors + 1;
                end
                mode    <= modeIdle;
                inBit   <= 1'b0;
                sdaPull <= 1'b0;
            end else if (!prevScl && scl) begin
                inBit <= 1'b1;
                if (bitCnt == 4'd8 && mode == modeRead) begin
                    // Master acknowledge after a byte we sent
                    masterAcked <= !sda;
                    if (sda) begin
                        nackCount <= nackCount + 1;
                    end else begin
                        ackCount <= ackCount + 1;
                    end
                end else if (bitCnt < 4'd8) begin
                    shiftIn <= {shiftIn[6:0], sda};
                end
            end else if (prevScl && !scl && inBit) begin
                inBit <= 1'b0;
                if (mode == modeIdle || mode == modeIgnore) begin
                    bitCnt <= 4'd0;
                end else if (bitCnt < 4'd7) begin
                    bitCnt <= bitCnt + 4'd1;
                    if (mode == modeRead) begin
                        txByte  <= {txByte[6:0], 1'b0};
                        sdaPull <= !txByte[6];
                    end
                end else if (bitCnt == 4'd7) begin
                    // Byte complete, set up the acknowledge slot
                    bitCnt  <= 4'd8;
                    sdaPull <= 1'b1;
                    case (mode)
                        modeAddr: begin
                            readDir <= shiftIn[0];
                            if (shiftIn[7:1] != DeviceAddr) begin
                                mode    <= modeIgnore;
                                sdaPull <= 1'b0;
                            end
                        end
                        modeReg: begin
                            pointer <= shiftIn[6:0];
                            autoInc <= shiftIn[7];
                        end
                        modeWrite: bank[pointer] <= shiftIn;
                        default:   sdaPull <= 1'b0;
                    endcase
                end else begin
                    bitCnt  <= 4'd0;
                    sdaPull <= 1'b0;
                    case (mode)
                        modeAddr: begin
                            if (readDir) begin
                                mode    <= modeRead;
                                txByte  <= bank[pointer];
                                sdaPull <= !bank[pointer][7];
                            end else begin
                                mode <= modeReg;
                            end
                        end
                        modeReg:  mode <= modeWrite;
                        modeRead: begin
                            if (masterAcked) begin
                                pointer <= nextPtr;
                                txByte  <= bank[nextPtr];
                                sdaPull <= !bank[nextPtr][7];
                            end else begin
                                mode <= modeIgnore;
                            end
                        end
                        default: mode <= mode;
                    endcase
                end
            end
        end
    end

endmodule

// File: hw/i2cMaster.sv
`timescale 1ns/1ps

module i2cMaster (
    input  logic              FSM_Clk,
    input  logic              reset,
    input  logic              startRequest,
    input  i2cPkg::addrT      slaveAddr,
    input  i2cPkg::addrT      subAddr,
    input  logic              readNotWrite,
    input  i2cPkg::byteT      writeData,
    input  i2cPkg::byteCountT byteCount,
    input  logic              sdaIn,
    output logic              scl,
    output logic              sdaOut,
    output logic              sdaOe,
    output logic              busy,
    output logic              readDone,
    output i2cPkg::readWordT  readData,
    output logic              ackBit
);

    logic              go;
    i2cPkg::byteT      addrWriteByte;
    i2cPkg::byteT      addrReadByte;
    i2cPkg::byteT      subAddrByte;
    i2cPkg::byteT      dataByte;
    logic              isRead;
    i2cPkg::byteCountT readCount;

    // Sequencer to bit engine
    i2cPkg::busCmdT    busCmd;
    logic              cmdValid;
    i2cPkg::byteT      txByte;
    logic              masterNack;
    logic              symbolDone;
    i2cPkg::byteT      rxByte;

    logic              rxStrobe;
    logic              rxLast;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////

    i2cRequestRegs requestRegs (
        .FSM_Clk(FSM_Clk), .reset(reset), .startRequest(startRequest),
        .slaveAddr(slaveAddr), .subAddr(subAddr), .readNotWrite(readNotWrite),
        .writeData(writeData), .byteCount(byteCount), .busy(busy), .go(go),
        .addrWriteByte(addrWriteByte), .addrReadByte(addrReadByte),
        .subAddrByte(subAddrByte), .dataByte(dataByte), .isRead(isRead),
        .readCount(readCount)
    );

    i2cSequencer sequencer (
        .FSM_Clk(FSM_Clk), .reset(reset), .go(go), .addrWriteByte(addrWriteByte),
        .addrReadByte(addrReadByte), .subAddrByte(subAddrByte), .dataByte(dataByte),
        .isRead(isRead), .readCount(readCount), .symbolDone(symbolDone), .busy(busy),
        .busCmd(busCmd), .cmdValid(cmdValid), .txByte(txByte), .masterNack(masterNack),
        .rxStrobe(rxStrobe), .rxLast(rxLast)
    );

    // Slave ACK register doubles as the ackBit output
    i2cBitEngine bitEngine (
        .FSM_Clk(FSM_Clk), .reset(reset), .busCmd(busCmd), .cmdValid(cmdValid),
        .txByte(txByte), .masterNack(masterNack), .sdaIn(sdaIn), .scl(scl),
        .sdaOut(sdaOut), .sdaOe(sdaOe), .symbolDone(symbolDone), .rxByte(rxByte),
        .slaveAck(ackBit)
    );

    i2cReadAssembler readAssembler (
        .FSM_Clk(FSM_Clk), .reset(reset), .go(go), .rxStrobe(rxStrobe), .rxLast(rxLast),
        .rxByte(rxByte), .readData(readData), .readDone(readDone)
    );

endmodule

// File: hw/i2cReadAssembler.sv
`timescale 1ns/1ps

module i2cReadAssembler (
    input  logic             FSM_Clk,
    input  logic             reset,
    input  logic             go,
    input  logic             rxStrobe,
    input  logic             rxLast,
    input  i2cPkg::byteT     rxByte,
    output i2cPkg::readWordT readData,
    output logic             readDone
);

    i2cPkg::readWordT shadow;
    i2cPkg::readWordT nextWord;

    // New byte enters at the bottom, earlier bytes move up
    assign nextWord = {shadow[23:0], rxByte};

    always_ff @(posedge FSM_Clk) begin
        if (go) begin
            shadow <= '0;
        end else if (rxStrobe) begin
            shadow <= nextWord;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result publish
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            readData <= '0;
            readDone <= 1'b0;
        end else begin
            readDone <= rxStrobe && rxLast;
            // Last byte of the read completes the word
            if (rxStrobe && rxLast) begin
                readData <= nextWord;
            end
        end
    end

endmodule

// File: hw/i2cBitEngine.sv
`timescale 1ns/1ps

module i2cBitEngine (
    input  logic           FSM_Clk,
    input  logic           reset,
    input  i2cPkg::busCmdT busCmd,
    input  logic           cmdValid,
    input  i2cPkg::byteT   txByte,
    input  logic           masterNack,
    input  logic           sdaIn,
    output logic           scl,
    output logic           sdaOut,
    output logic           sdaOe,
    output logic           symbolDone,
    output i2cPkg::byteT   rxByte,
    output logic           slaveAck
);

    // Symbol on the bus; kept after it ends so both lines hold their level
    i2cPkg::busCmdT curCmd;
    logic           active;
    logic [1:0]     phase;
    logic [3:0]     bitCount;
    i2cPkg::byteT   txShift;
    i2cPkg::byteT   rxShift;
    logic           nackHeld;
    logic           lastStep;
    logic           bitHigh;
    logic           ackSlot;
    logic           samplePoint;

    assign bitHigh     = (phase == 2'd1) || (phase == 2'd2);
    assign ackSlot     = bitCount == 4'(i2cPkg::BitsPerFrame - 1);
    assign samplePoint = active && (phase == 2'd2);

    always_comb begin
        case (curCmd)
            i2cPkg::cmdStart: lastStep = phase == 2'(i2cPkg::StartCycles - 1);
            i2cPkg::cmdStop:  lastStep = phase == 2'(i2cPkg::StopCycles - 1);
            default:          lastStep = ackSlot && (phase == 2'(i2cPkg::PhasesPerBit - 1));
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Line levels per step
    //////////////////////////////////////////////////////////////////////

    // Open drain, the pad only ever pulls low
    assign sdaOut = 1'b0;

    always_comb begin
        case (curCmd)
            i2cPkg::cmdStart: begin
                // SDA falls in the middle of the SCL high pulse
                scl   = bitHigh;
                sdaOe = phase[1];
            end
            i2cPkg::cmdStop: begin
                // SDA released last, with SCL already high
                scl   = phase != 2'd0;
                sdaOe = phase != 2'd2;
            end
            i2cPkg::cmdWriteByte: begin
                scl   = bitHigh;
                sdaOe = !ackSlot && !txShift[7];
            end
            default: begin
                // Master ACK drives low, NACK leaves the line released
                scl   = bitHigh;
                sdaOe = ackSlot && !nackHeld;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Phase and bit counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            active     <= 1'b0;
            curCmd     <= i2cPkg::cmdStop;
            phase      <= 2'(i2cPkg::StopCycles - 1);
            bitCount   <= '0;
            symbolDone <= 1'b0;
            slaveAck   <= 1'b1;
        end else begin
            symbolDone <= 1'b0;
            if (cmdValid && !active) begin
                active   <= 1'b1;
                curCmd   <= busCmd;
                phase    <= '0;
                bitCount <= '0;
            end else if (active) begin
                if (lastStep) begin
                    active     <= 1'b0;
                    symbolDone <= 1'b1;
                end else if (phase == 2'(i2cPkg::PhasesPerBit - 1)) begin
                    phase    <= '0;
                    bitCount <= bitCount + 4'd1;
                end else begin
                    phase <= phase + 2'd1;
                end
            end
            // Slave ACK slot of a byte sent by the master
            if (samplePoint && ackSlot && curCmd == i2cPkg::cmdWriteByte) begin
                slaveAck <= sdaIn;
            end
        end
    end

    // Data shifters
    always_ff @(posedge FSM_Clk) begin
        if (cmdValid && !active) begin
            txShift  <= txByte;
            nackHeld <= masterNack;
        end else if (active && !lastStep && phase == 2'(i2cPkg::PhasesPerBit - 1)) begin
            txShift <= {txShift[6:0], 1'b0};
        end
        if (samplePoint && !ackSlot && curCmd == i2cPkg::cmdReadByte) begin
            rxShift <= {rxShift[6:0], sdaIn};
        end
    end

    assign rxByte = rxShift;

    // Only START and STOP may move SDA under a high SCL
    assert property (@(posedge FSM_Clk) disable iff (reset)
        (scl && $past(scl) && (sdaOe != $past(sdaOe)))
            |-> (curCmd == i2cPkg::cmdStart || curCmd == i2cPkg::cmdStop));

endmodule

// File: hw/i2cSequencer.sv
`timescale 1ns/1ps

module i2cSequencer (
    input  logic              FSM_Clk,
    input  logic              reset,
    input  logic              go,
    input  i2cPkg::byteT      addrWriteByte,
    input  i2cPkg::byteT      addrReadByte,
    input  i2cPkg::byteT      subAddrByte,
    input  i2cPkg::byteT      dataByte,
    input  logic              isRead,
    input  i2cPkg::byteCountT readCount,
    input  logic              symbolDone,
    output logic              busy,
    output i2cPkg::busCmdT    busCmd,
    output logic              cmdValid,
    output i2cPkg::byteT      txByte,
    output logic              masterNack,
    output logic              rxStrobe,
    output logic              rxLast
);

    i2cPkg::seqStateT  state;
    i2cPkg::seqStateT  nextState;
    // Read bytes still to come, including the one on the bus
    i2cPkg::byteCountT bytesLeft;
    logic              lastRead;

    assign busy     = state != i2cPkg::stIdle;
    assign lastRead = bytesLeft == 3'd1;

    //////////////////////////////////////////////////////////////////////
    // Transaction order
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        case (state)
            i2cPkg::stIdle: begin
                if (go) nextState = i2cPkg::stStart;
            end
            i2cPkg::stStart: begin
                if (symbolDone) nextState = i2cPkg::stSlaveWrite;
            end
            i2cPkg::stSlaveWrite: begin
                if (symbolDone) nextState = i2cPkg::stSubAddr;
            end
            i2cPkg::stSubAddr: begin
                // Reads turn the bus around with a repeated START
                if (symbolDone) nextState = isRead ? i2cPkg::stRestart : i2cPkg::stWriteData;
            end
            i2cPkg::stWriteData: begin
                if (symbolDone) nextState = i2cPkg::stStop;
            end
            i2cPkg::stRestart: begin
                if (symbolDone) nextState = i2cPkg::stSlaveRead;
            end
            i2cPkg::stSlaveRead: begin
                if (symbolDone) nextState = i2cPkg::stReadData;
            end
            i2cPkg::stReadData: begin
                if (symbolDone && lastRead) nextState = i2cPkg::stStop;
            end
            i2cPkg::stStop: begin
                if (symbolDone) nextState = i2cPkg::stIdle;
            end
            default: nextState = i2cPkg::stIdle;
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            state     <= i2cPkg::stIdle;
            cmdValid  <= 1'b0;
            bytesLeft <= '0;
        end else begin
            state <= nextState;
            // One symbol per state, issued the cycle after entering it
            cmdValid <= (go && state == i2cPkg::stIdle) ||
                        (symbolDone && nextState != i2cPkg::stIdle);
            if (symbolDone && state == i2cPkg::stSlaveRead) begin
                bytesLeft <= readCount;
            end else if (symbolDone && state == i2cPkg::stReadData) begin
                bytesLeft <= bytesLeft - 3'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Symbol contents
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        busCmd = i2cPkg::cmdWriteByte;
        txByte = addrWriteByte;
        case (state)
            i2cPkg::stStart,
            i2cPkg::stRestart:   busCmd = i2cPkg::cmdStart;
            i2cPkg::stSubAddr:   txByte = subAddrByte;
            i2cPkg::stWriteData: txByte = dataByte;
            i2cPkg::stSlaveRead: txByte = addrReadByte;
            i2cPkg::stReadData:  busCmd = i2cPkg::cmdReadByte;
            i2cPkg::stIdle,
            i2cPkg::stStop:      busCmd = i2cPkg::cmdStop;
            default:             txByte = addrWriteByte;
        endcase
    end

    // Final read byte gets a NACK
    assign masterNack = lastRead;
    assign rxStrobe   = symbolDone && state == i2cPkg::stReadData;
    assign rxLast     = lastRead;

    assert property (@(posedge FSM_Clk) disable iff (reset) cmdValid |-> state != i2cPkg::stIdle);

endmodule

// File: hw/i2cRequestRegs.sv
`timescale 1ns/1ps

module i2cRequestRegs (
    input  logic              FSM_Clk,
    input  logic              reset,
    input  logic              startRequest,
    input  i2cPkg::addrT      slaveAddr,
    input  i2cPkg::addrT      subAddr,
    input  logic              readNotWrite,
    input  i2cPkg::byteT      writeData,
    input  i2cPkg::byteCountT byteCount,
    input  logic              busy,
    output logic              go,
    output i2cPkg::byteT      addrWriteByte,
    output i2cPkg::byteT      addrReadByte,
    output i2cPkg::byteT      subAddrByte,
    output i2cPkg::byteT      dataByte,
    output logic              isRead,
    output i2cPkg::byteCountT readCount
);

    i2cPkg::byteCountT clampedCount;
    i2cPkg::byteT      frameSubAddr;

    // Requests arriving mid-transaction are dropped
    assign go = startRequest && !busy;

    always_comb begin
        if (byteCount == 3'd0) begin
            clampedCount = 3'd1;
        end else if (byteCount > i2cPkg::MaxReadBytes) begin
            clampedCount = i2cPkg::MaxReadBytes;
        end else begin
            clampedCount = byteCount;
        end
    end

    // Multi-byte reads ask the sensor to step its pointer
    always_comb begin
        frameSubAddr = {1'b0, subAddr};
        frameSubAddr[i2cPkg::AutoIncrementBit] = readNotWrite && (clampedCount > 3'd1);
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            isRead    <= 1'b0;
            readCount <= 3'd1;
        end else if (go) begin
            isRead    <= readNotWrite;
            readCount <= clampedCount;
        end
    end

    // Frame bytes
    always_ff @(posedge FSM_Clk) begin
        if (go) begin
            addrWriteByte <= {slaveAddr, 1'b0};
            addrReadByte  <= {slaveAddr, 1'b1};
            subAddrByte   <= frameSubAddr;
            dataByte      <= writeData;
        end
    end

    // An accepted request turns the sequencer busy on the next cycle
    assert property (@(posedge FSM_Clk) disable iff (reset) go |-> !busy ##1 busy);

endmodule

// File: hw/i2cPkg.sv
package i2cPkg;

    //////////////////////////////////////////////////////////////////////
    // Vector types
    //////////////////////////////////////////////////////////////////////

    // Slave address or register pointer, without the direction bit
    typedef logic [6:0]  addrT;
    typedef logic [7:0]  byteT;
    typedef logic [2:0]  byteCountT;
    typedef logic [31:0] readWordT;

    //////////////////////////////////////////////////////////////////////
    // Bus timing, counted in FSM_Clk cycles
    //////////////////////////////////////////////////////////////////////

    localparam int PhasesPerBit = 4;
    // Eight data bits and the acknowledge slot
    localparam int BitsPerFrame = 9;
    localparam int StartCycles  = 4;
    localparam int StopCycles   = 3;

    // Read request limits
    localparam byteCountT MaxReadBytes = 3'd4;
    // Sensor auto-increment flag in the sub-address byte
    localparam int AutoIncrementBit = 7;

    // Bus symbols handed to the bit engine
    typedef enum logic [1:0] {
        cmdStart,
        cmdStop,
        cmdWriteByte,
        cmdReadByte
    } busCmdT;

    // Transaction steps, one bus symbol each
    typedef enum logic [3:0] {
        stIdle,
        stStart,
        stSlaveWrite,
        stSubAddr,
        stWriteData,
        stRestart,
        stSlaveRead,
        stReadData,
        stStop
    } seqStateT;

endpackage
